/* hw/bpi_pkg.sv */
`default_nettype none

package bpi_pkg;

	//////////////////////////////////////////////////
	// Widths and sizes
	//////////////////////////////////////////////////
	localparam int FIFO_DEPTH = 1024;
	localparam int CNT_W = 11;

	typedef logic [15:0]      word_t;        // Data or command FIFO word
	typedef logic [22:0]      flash_addr_t;  // PROM word address
	typedef logic [6:0]       blk_base_t;
	typedef logic [15:0]      offset_t;
	typedef logic [CNT_W-1:0] wcount_t;      // Word count, header count field
	typedef logic [7:0]       sr_t;          // Flash status register

	// Host command codes
	typedef enum logic [4:0] {
		cmd_noop            = 5'h00,
		cmd_read_n          = 5'h04,
		cmd_read_array      = 5'h05,
		cmd_read_status_reg = 5'h06,
		cmd_clr_status_reg  = 5'h09,
		cmd_block_erase     = 5'h0A,
		cmd_program         = 5'h0B,
		cmd_load_address    = 5'h17,  // Local
		cmd_clr_bpi_status  = 5'h1C   // Local
	} cmd_t;

	typedef enum logic [1:0] {op_none = 2'd0, op_write = 2'd1, op_read = 2'd2} bpi_op_t;

	// Where a read lands
	typedef enum logic [1:0] {dest_none, dest_readback, dest_status} read_dest_t;

	typedef enum logic [1:0] {dec_idle, dec_extra, dec_dispatch, dec_wait} decode_state_t;

	typedef enum logic [2:0] {
		ex_idle, ex_cmd1, ex_cmd2, ex_rd_array, ex_rd_sr, ex_wait_rise, ex_wait_fall, ex_done
	} exec_state_t;

	//////////////////////////////////////////////////
	// Flash opcodes and address masks
	//////////////////////////////////////////////////
	localparam word_t OPC_READ_ARRAY = 16'h00FF;
	localparam word_t OPC_READ_SR    = 16'h0070;
	localparam word_t OPC_CLR_SR     = 16'h0050;
	localparam word_t OPC_ERASE      = 16'h0020;
	localparam word_t OPC_CONFIRM    = 16'h00D0;
	localparam word_t OPC_PROGRAM    = 16'h0040;

	localparam flash_addr_t BANK_MASK          = 23'h780000;
	localparam flash_addr_t MAIN_BLOCK_MASK    = 23'h7F0000;  // 64 K-word blocks
	localparam flash_addr_t PARAM_BLOCK_MASK   = 23'h7FC000;  // 16 K-word blocks
	localparam flash_addr_t PARAM_REGION_START = 23'h7F0000;

	localparam int  SR_READY_BIT      = 7;
	localparam sr_t SR_ERASE_ERR_MASK = 8'h2A;
	localparam sr_t SR_PROG_ERR_MASK  = 8'h1A;

	// Decode to execute
	typedef struct packed {
		cmd_t    cmd;
		wcount_t count;  // Words minus one
		word_t   data;
	} flash_req_t;

	typedef struct packed {
		logic      load;
		blk_base_t base;
		offset_t   offset;
	} addr_load_t;

	typedef struct packed {
		bpi_op_t     op;
		flash_addr_t addr;
		word_t       data;
	} bus_cycle_t;

	typedef struct packed {
		logic empty;
		logic full;
		logic overflow;
		logic underflow;
	} fifo_flags_t;

endpackage

`default_nettype wire

/* hw/bpi_fifo.sv */
`default_nettype none

module bpi_fifo import bpi_pkg::*;
#(
	parameter int DEPTH = FIFO_DEPTH
)
(
	input  wire logic CLK,
	input  wire logic local_rst,
	input  wire logic push,
	input  word_t     push_data,
	input  wire logic pop,
	output word_t     pop_data,
	output wcount_t   count,
	output logic      empty,
	output logic      full,
	output logic      overflow,
	output logic      underflow
);

	word_t                     mem [DEPTH];
	logic [$clog2(DEPTH)-1:0]  wr_ptr;
	logic [$clog2(DEPTH)-1:0]  rd_ptr;
	logic                      do_push;
	logic                      do_pop;

	assign empty = (count == '0);
	assign full  = (count == wcount_t'(DEPTH));

	// Dropped push or empty pop
	assign do_push   = push && !full;
	assign do_pop    = pop && !empty;
	assign overflow  = push && full;
	assign underflow = pop && empty;

	assign pop_data = mem[rd_ptr];  // Head word falls through

	always_ff @(posedge CLK)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/bpi_cmd_decode.sv */
`default_nettype none

module bpi_cmd_decode import bpi_pkg::*;
(
	input  wire logic CLK,
	input  wire logic local_rst,
	input  wire logic enbl,
	input  wire logic dsbl,
	input  word_t     fifo_word,
	input  wire logic fifo_empty,
	output logic      pop,
	output logic      start,
	output flash_req_t req,
	output addr_load_t addr_load,
	input  wire logic done,
	output logic      clear_sticky
);

	decode_state_t state;
	logic          enabled;
	cmd_t          head_cmd;
	cmd_t          hdr_cmd;
	wcount_t       hdr_field;  // Count or address base
	word_t         xtra_data;

	// Commands followed by one more FIFO word
	function automatic logic needs_xtra(cmd_t c);
		needs_xtra = (c == cmd_load_address) || (c == cmd_program);
	endfunction

	function automatic logic is_flash(cmd_t c);
		case (c)
			cmd_noop, cmd_read_n, cmd_read_array, cmd_read_status_reg,
			cmd_clr_status_reg, cmd_block_erase, cmd_program:
				is_flash = 1'b1;
			default:
				is_flash = 1'b0;
		endcase
	endfunction

	assign head_cmd = cmd_t'(fifo_word[4:0]);

	// Enable wins over disable
	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
			enabled <= 1'b0;
		else if (enbl)
			enabled <= 1'b1;
		else if (dsbl)
			enabled <= 1'b0;
	end

	//////////////////////////////////////////////////
	// Parser
	//////////////////////////////////////////////////
	assign pop = ((state == dec_idle) && enabled && !fifo_empty) ||
		((state == dec_extra) && !fifo_empty);

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
			state <= dec_idle;
		else
		begin
			case (state)
				dec_idle:
					if (pop)
						state <= needs_xtra(head_cmd) ? dec_extra : dec_dispatch;
				dec_extra:
					if (pop)
						state <= dec_dispatch;
				dec_dispatch:
					state <= is_flash(hdr_cmd) ? dec_wait : dec_idle;  // Unknown codes dropped
				dec_wait:
					if (done)
						state <= dec_idle;
				default:
					state <= dec_idle;
			endcase
		end
	end

	// Header and data word
	always_ff @(posedge CLK)
	begin
		if ((state == dec_idle) && pop)
		begin
			hdr_cmd   <= head_cmd;
			hdr_field <= fifo_word[15:5];
		end
		if ((state == dec_extra) && pop)
			xtra_data <= fifo_word;
	end

	assign start        = (state == dec_dispatch) && is_flash(hdr_cmd);
	assign clear_sticky = (state == dec_dispatch) && (hdr_cmd == cmd_clr_bpi_status);

	assign addr_load.load   = (state == dec_dispatch) && (hdr_cmd == cmd_load_address);
	assign addr_load.base   = hdr_field[6:0];
	assign addr_load.offset = xtra_data;

	assign req.cmd   = hdr_cmd;   // Held until done
	assign req.count = hdr_field;
	assign req.data  = xtra_data;

endmodule

`default_nettype wire

/* hw/bpi_execute.sv */
`default_nettype none

module bpi_execute import bpi_pkg::*;
(
	input  wire logic CLK,
	input  wire logic local_rst,
	input  wire logic start,
	input  flash_req_t req,
	input  addr_load_t addr_load,
	output logic      done,
	input  sr_t       sr,
	input  wire logic busy,
	output bus_cycle_t bus,
	output logic      execute,
	output read_dest_t dest
);

	exec_state_t state;
	exec_state_t state_n;
	exec_state_t step;       // Bus cycle in flight
	blk_base_t   base;
	offset_t     offset;
	wcount_t     rd_left;    // Reads still owed after this one
	flash_addr_t waddr;
	flash_addr_t bank_addr;
	flash_addr_t block_addr;
	logic        two_cycle;
	logic        cycle_end;
	logic        last_read;

	//////////////////////////////////////////////////
	// Addresses
	//////////////////////////////////////////////////
	assign waddr     = {base, offset};
	assign bank_addr = waddr & BANK_MASK;

	always_comb
	begin
		if (waddr >= PARAM_REGION_START)
			block_addr = waddr & PARAM_BLOCK_MASK;
		else
			block_addr = waddr & MAIN_BLOCK_MASK;
	end

	assign two_cycle = (req.cmd == cmd_block_erase) || (req.cmd == cmd_program);
	assign cycle_end = (state == ex_wait_fall) && !busy;
	assign last_read = (rd_left == '0);

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////
	always_comb
	begin
		state_n = state;
		case (state)
			ex_idle:
				if (start)
				begin
					case (req.cmd)
						cmd_noop:   state_n = ex_done;
						cmd_read_n: state_n = ex_rd_array;
						default:    state_n = ex_cmd1;
					endcase
				end
			ex_cmd1, ex_cmd2, ex_rd_array, ex_rd_sr:
				state_n = ex_wait_rise;  // One-cycle execute pulse
			ex_wait_rise:
				if (busy)
					state_n = ex_wait_fall;
			ex_wait_fall:
				if (!busy)
				begin
					case (step)
						ex_cmd1:
							if (two_cycle)
								state_n = ex_cmd2;
							else if (req.cmd == cmd_read_status_reg)
								state_n = ex_rd_sr;
							else
								state_n = ex_done;
						ex_cmd2:
							state_n = ex_rd_sr;  // Start polling
						ex_rd_array:
							state_n = last_read ? ex_done : ex_rd_array;
						ex_rd_sr:
							if ((req.cmd == cmd_read_status_reg) || sr[SR_READY_BIT])
								state_n = ex_done;
							else
								state_n = ex_rd_sr;
						default:
							state_n = ex_done;
					endcase
				end
			default:
				state_n = ex_idle;
		endcase
	end

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
		begin
			state   <= ex_idle;
			step    <= ex_idle;
			base    <= '0;
			offset  <= '0;
			rd_left <= '0;
		end
		else
		begin
			state <= state_n;
			if (state_n inside {ex_cmd1, ex_cmd2, ex_rd_array, ex_rd_sr})
				step <= state_n;
			else if (state_n == ex_done)
				step <= ex_idle;

			if (addr_load.load)
			begin
				base   <= addr_load.base;
				offset <= addr_load.offset;
			end
			else if (cycle_end && (step == ex_rd_array))
				offset <= offset + 1'b1;  // Next array word

			if ((state == ex_idle) && start)
				rd_left <= req.count;
			else if (cycle_end && (step == ex_rd_array) && !last_read)
				rd_left <= rd_left - 1'b1;
		end
	end

	assign execute = state inside {ex_cmd1, ex_cmd2, ex_rd_array, ex_rd_sr};
	assign done    = (state == ex_done);

	// Bus cycle contents, held while the cycle runs
	always_comb
	begin
		bus.op   = op_none;
		bus.addr = bank_addr;
		bus.data = '0;
		dest     = dest_none;
		case (step)
			ex_cmd1:
			begin
				bus.op = op_write;
				case (req.cmd)
					cmd_read_array:      bus.data = OPC_READ_ARRAY;
					cmd_read_status_reg: bus.data = OPC_READ_SR;
					cmd_clr_status_reg:  bus.data = OPC_CLR_SR;
					cmd_block_erase:
					begin
						bus.addr = block_addr;
						bus.data = OPC_ERASE;
					end
					cmd_program:
					begin
						bus.addr = waddr;
						bus.data = OPC_PROGRAM;
					end
					default: ;
				endcase
			end
			ex_cmd2:
			begin
				bus.op = op_write;
				if (req.cmd == cmd_block_erase)
				begin
					bus.addr = block_addr;
					bus.data = OPC_CONFIRM;
				end
				else
				begin
					bus.addr = waddr;
					bus.data = req.data;  // Program data
				end
			end
			ex_rd_array:
			begin
				bus.op   = op_read;
				bus.addr = waddr;
				dest     = dest_readback;
			end
			ex_rd_sr:
			begin
				bus.op = op_read;
				dest   = dest_status;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

/* hw/bpi_result.sv */
`default_nettype none

module bpi_result import bpi_pkg::*;
(
	input  wire logic  CLK,
	input  wire logic  local_rst,
	input  wire logic  load_data,
	input  word_t      data_from,
	input  read_dest_t dest,
	output logic       rbk_push,
	output sr_t        sr,
	input  fifo_flags_t cmd_flags,
	input  fifo_flags_t rbk_flags,
	input  wire logic  clear_sticky,
	output word_t      status
);

	sr_t        sr_reg;
	logic       sr_load;
	logic [3:0] sticky_n;  // rbk unf, rbk ovf, cmd unf, cmd ovf

	assign sr_load  = load_data && (dest == dest_status);
	assign rbk_push = load_data && (dest == dest_readback);

	// New value visible in the load cycle
	assign sr = sr_load ? data_from[7:0] : sr_reg;

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
			sr_reg <= '0;
		else if (sr_load)
			sr_reg <= data_from[7:0];
	end

	//////////////////////////////////////////////////
	// Status word
	//////////////////////////////////////////////////
	always_comb
	begin
		if (clear_sticky)
			sticky_n = '0;
		else
			sticky_n = {rbk_flags.underflow | status[13], rbk_flags.overflow | status[12],
				cmd_flags.underflow | status[9], cmd_flags.overflow | status[8]};
	end

	always_ff @(posedge CLK or posedge local_rst)
	begin
		if (local_rst)
			status <= '0;
		else
			status <= {rbk_flags.empty, rbk_flags.full, sticky_n[3:2],
				cmd_flags.empty, cmd_flags.full, sticky_n[1:0], sr};
	end

endmodule

`default_nettype wire

/* hw/bpi_ctrl.sv */
`default_nettype none

module bpi_ctrl import bpi_pkg::*;
(
	input  wire logic CLK,
	input  wire logic local_rst,

	// Host side
	input  word_t     bpi_cmd_fifo_data,
	input  wire logic bpi_we,             // One pulse per command word
	input  wire logic bpi_re,             // One pulse per readback word
	input  wire logic bpi_dsbl,
	input  wire logic bpi_enbl,
	output word_t     bpi_rbk_fifo_data,
	output wcount_t   bpi_rbk_wrd_cnt,
	output word_t     bpi_status,

	// Low-level flash interface
	input  wire logic bpi_busy,
	input  word_t     bpi_data_from,
	input  wire logic bpi_load_data,
	output bpi_op_t   bpi_op,
	output flash_addr_t bpi_addr,
	output word_t     bpi_data_to,
	output logic      bpi_execute
);

	word_t       cmd_word;
	logic        cmd_pop;
	logic        cmd_empty;
	logic        cmd_full;
	logic        cmd_ovf;
	logic        cmd_unf;
	logic        rbk_push;
	logic        rbk_empty;
	logic        rbk_full;
	logic        rbk_ovf;
	logic        rbk_unf;
	fifo_flags_t cmd_flags;
	fifo_flags_t rbk_flags;
	logic        start;
	logic        done;
	logic        clear_sticky;
	flash_req_t  req;
	addr_load_t  addr_load;
	bus_cycle_t  bus;
	read_dest_t  dest;
	sr_t         sr;

	//////////////////////////////////////////////////
	// FIFOs
	//////////////////////////////////////////////////
	bpi_fifo #(.DEPTH(FIFO_DEPTH)) cmd_fifo (
		.CLK       (CLK),
		.local_rst (local_rst),
		.push      (bpi_we),
		.push_data (bpi_cmd_fifo_data),
		.pop       (cmd_pop),
		.pop_data  (cmd_word),
		.count     (),
		.empty     (cmd_empty),
		.full      (cmd_full),
		.overflow  (cmd_ovf),
		.underflow (cmd_unf)
	);

	// Array reads for the host
	bpi_fifo #(.DEPTH(FIFO_DEPTH)) rbk_fifo (
		.CLK       (CLK),
		.local_rst (local_rst),
		.push      (rbk_push),
		.push_data (bpi_data_from),
		.pop       (bpi_re),
		.pop_data  (bpi_rbk_fifo_data),
		.count     (bpi_rbk_wrd_cnt),
		.empty     (rbk_empty),
		.full      (rbk_full),
		.overflow  (rbk_ovf),
		.underflow (rbk_unf)
	);

	assign cmd_flags = '{empty: cmd_empty, full: cmd_full, overflow: cmd_ovf, underflow: cmd_unf};
	assign rbk_flags = '{empty: rbk_empty, full: rbk_full, overflow: rbk_ovf, underflow: rbk_unf};

	//////////////////////////////////////////////////
	// Decode, execute, result
	//////////////////////////////////////////////////
	bpi_cmd_decode decode_i (
		.CLK          (CLK),
		.local_rst    (local_rst),
		.enbl         (bpi_enbl),
		.dsbl         (bpi_dsbl),
		.fifo_word    (cmd_word),
		.fifo_empty   (cmd_empty),
		.pop          (cmd_pop),
		.start        (start),
		.req          (req),
		.addr_load    (addr_load),
		.done         (done),
		.clear_sticky (clear_sticky)
	);

	bpi_execute execute_i (
		.CLK       (CLK),
		.local_rst (local_rst),
		.start     (start),
		.req       (req),
		.addr_load (addr_load),
		.done      (done),
		.sr        (sr),
		.busy      (bpi_busy),
		.bus       (bus),
		.execute   (bpi_execute),
		.dest      (dest)
	);

	bpi_result result_i (
		.CLK          (CLK),
		.local_rst    (local_rst),
		.load_data    (bpi_load_data),
		.data_from    (bpi_data_from),
		.dest         (dest),
		.rbk_push     (rbk_push),
		.sr           (sr),
		.cmd_flags    (cmd_flags),
		.rbk_flags    (rbk_flags),
		.clear_sticky (clear_sticky),
		.status       (bpi_status)
	);

	// Flash side bus
	assign bpi_op      = bus.op;
	assign bpi_addr    = bus.addr;
	assign bpi_data_to = bus.data;

endmodule

`default_nettype wire

/* bench/bpi_flash_model.sv */
`default_nettype none

module bpi_flash_model import bpi_pkg::*;
#(
	parameter flash_addr_t PROT_ADDR = 23'h1234F0
)
(
	input  wire logic   CLK,
	input  bpi_op_t     bpi_op,
	input  flash_addr_t bpi_addr,
	input  word_t       bpi_data_to,
	input  wire logic   bpi_execute,
	output logic        bpi_busy,
	output word_t       bpi_data_from,
	output logic        bpi_load_data
);

	localparam logic [31:0] SEED = 32'haa70;

	word_t       mem [flash_addr_t];
	flash_addr_t last_erase_addr;  // Address of the last erase confirm
	sr_t         status;
	logic        rd_status;        // Status or array read mode
	word_t       last_cmd;
	logic [31:0] rng;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic write_cycle(input flash_addr_t a, input word_t d);
		flash_addr_t blk;
		int          size;
		if (last_cmd == OPC_PROGRAM)
		begin
			if (a == PROT_ADDR)
				status = 8'h90;  // Program error, ready
			else
				mem[a] = (mem.exists(a) ? mem[a] : 16'hFFFF) & d;
			last_cmd = '0;
		end
		else if ((last_cmd == OPC_ERASE) && (d == OPC_CONFIRM))
		begin
			last_erase_addr = a;
			size = (a >= PARAM_REGION_START) ? 32'h4000 : 32'h10000;
			blk = a & ~flash_addr_t'(size - 1);
			for (int i = 0; i < size; i++)
				mem[blk + flash_addr_t'(i)] = 16'hFFFF;
			last_cmd = '0;
		end
		else
		begin
			last_cmd = d;
			case (d)
				OPC_READ_ARRAY: rd_status = 1'b0;
				OPC_CLR_SR:     status = 8'h80;
				default:        rd_status = 1'b1;
			endcase
		end
	endtask

	initial
	begin
		int          lat;
		logic        is_read;
		word_t       rd_word;
		logic [31:0] h;
		bpi_busy = 1'b0;
		bpi_data_from = '0;
		bpi_load_data = 1'b0;
		status = 8'h80;
		rd_status = 1'b0;
		last_cmd = '0;
		last_erase_addr = '0;
		rng = SEED;
		// Preload window, each word hashed from its full address
		for (int i = 0; i < 256; i++)
		begin
			h = xorshift32(SEED ^ {9'b0, 23'h123400 + flash_addr_t'(i)});
			mem[23'h123400 + flash_addr_t'(i)] = h[15:0];
		end

		//////////////////////////////////////////////////
		// Bus cycle responder
		//////////////////////////////////////////////////
		forever
		begin
			@(negedge CLK);
			if (bpi_execute)
			begin
				rng = xorshift32(rng);
				lat = int'(rng[2:0]) + 1;  // 1 to 8 cycles busy
				is_read = (bpi_op == op_read);
				if (!is_read)
					write_cycle(bpi_addr, bpi_data_to);
				else if (rd_status)
					rd_word = {8'h00, status};
				else
					rd_word = mem.exists(bpi_addr) ? mem[bpi_addr] : 16'hFFFF;
				@(negedge CLK);
				bpi_busy = 1'b1;
				repeat (lat) @(negedge CLK);
				if (is_read)
				begin
					bpi_data_from = rd_word;
					bpi_load_data = 1'b1;
					@(negedge CLK);
					bpi_load_data = 1'b0;
				end
				bpi_busy = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* bench/bpi_ctrl_asserts.sv */
`default_nettype none

module bpi_ctrl_asserts import bpi_pkg::*;
(
	input  wire logic CLK,
	input  wire logic local_rst,
	input  wire logic bpi_execute,
	input  wire logic bpi_busy,
	input  bpi_op_t   bpi_op,
	input  wcount_t   bpi_rbk_wrd_cnt
);

	// Execute is a single-cycle pulse
	execute_one_cycle: assert property (@(posedge CLK) disable iff (local_rst)
		!(bpi_execute && $past(bpi_execute)))
		else $error("bpi_execute stayed high for two cycles");

	execute_not_busy: assert property (@(posedge CLK) disable iff (local_rst)
		!(bpi_execute && bpi_busy))
		else $error("bpi_execute pulsed while bpi_busy was high");

	execute_op_valid: assert property (@(posedge CLK) disable iff (local_rst)
		!bpi_execute || (bpi_op == op_read) || (bpi_op == op_write))
		else $error("bpi_op is neither read nor write on execute");

	rbk_count_range: assert property (@(posedge CLK) disable iff (local_rst)
		bpi_rbk_wrd_cnt <= wcount_t'(FIFO_DEPTH))
		else $error("readback word count above FIFO depth");

endmodule

bind bpi_ctrl bpi_ctrl_asserts ctrl_asserts (
	.CLK             (CLK),
	.local_rst       (local_rst),
	.bpi_execute     (bpi_execute),
	.bpi_busy        (bpi_busy),
	.bpi_op          (bpi_op),
	.bpi_rbk_wrd_cnt (bpi_rbk_wrd_cnt)
);

`default_nettype wire

/* bench/bpi_ctrl_tb.sv */
`default_nettype none

module bpi_ctrl_tb import bpi_pkg::*;
();

	localparam int          TIMEOUT   = 2000;
	localparam flash_addr_t PROT_ADDR = 23'h1234F0;

	logic        CLK;
	logic        local_rst;
	word_t       bpi_cmd_fifo_data;
	logic        bpi_we;
	logic        bpi_re;
	logic        bpi_dsbl;
	logic        bpi_enbl;
	word_t       bpi_rbk_fifo_data;
	wcount_t     bpi_rbk_wrd_cnt;
	word_t       bpi_status;
	logic        bpi_busy;
	word_t       bpi_data_from;
	logic        bpi_load_data;
	bpi_op_t     bpi_op;
	flash_addr_t bpi_addr;
	word_t       bpi_data_to;
	logic        bpi_execute;
	word_t       rbk_words [$];  // Last batch popped from readback

	bpi_ctrl uut (.*);

	bpi_flash_model #(.PROT_ADDR(PROT_ADDR)) flash (.*);

	initial
	begin
		CLK = 1'b0;
		forever
			#5 CLK = ~CLK;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic expect_true(input logic ok, input string msg);
		assert (ok) else stop_run($sformatf("error %0t: %s", $time, msg));
	endtask

	task automatic write_word(input word_t w);
		bpi_cmd_fifo_data = w;
		bpi_we = 1'b1;
		@(negedge CLK);
		bpi_we = 1'b0;
	endtask

	task automatic send_cmd(input cmd_t c, input wcount_t field);
		write_word({field, c});  // Count or base above the code
	endtask

	task automatic load_address(input flash_addr_t a);
		write_word({4'b0, a[22:16], cmd_load_address});
		write_word(a[15:0]);
	endtask

	task automatic wait_done(input string what);
		int n;
		n = 0;
		do
		begin
			@(negedge CLK);
			n++;
			if (n > TIMEOUT)
				stop_run($sformatf("Timed out waiting for %s to complete", what));
		end
		while (!uut.done);
	endtask

	task automatic pop_word(output word_t w);
		w = bpi_rbk_fifo_data;  // Head word falls through
		bpi_re = 1'b1;
		@(negedge CLK);
		bpi_re = 1'b0;
	endtask

	// Array read of n words from a into rbk_words
	task automatic read_words(input flash_addr_t a, input int n);
		word_t w;
		rbk_words.delete();
		load_address(a);
		send_cmd(cmd_read_array, '0);
		wait_done("Read_Array");
		send_cmd(cmd_read_n, wcount_t'(n - 1));
		wait_done("Read_n");
		expect_true(bpi_rbk_wrd_cnt == wcount_t'(n),
			$sformatf("readback count %0d, expected %0d", bpi_rbk_wrd_cnt, n));
		for (int i = 0; i < n; i++)
		begin
			pop_word(w);
			rbk_words.push_back(w);
		end
	endtask

	// Zero one word first so the erase has a visible effect
	task automatic erase_and_check(input flash_addr_t a, input flash_addr_t blk);
		load_address(a);
		write_word({11'd0, cmd_program});
		write_word(16'h0000);
		wait_done("Program before erase");
		send_cmd(cmd_block_erase, '0);
		wait_done("Block_Erase");
		expect_true(flash.last_erase_addr == blk, $sformatf(
			"erase address %h, expected %h", flash.last_erase_addr, blk));
		read_words(a, 4);
		for (int i = 0; i < 4; i++)
			expect_true(rbk_words[i] == 16'hFFFF,
				$sformatf("erased word %0d is %h", i, rbk_words[i]));
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////
	initial
	begin
		flash_addr_t a;
		word_t       old_word;
		word_t       w;
		int          n;

		local_rst = 1'b1;
		bpi_cmd_fifo_data = '0;
		bpi_we = 1'b0;
		bpi_re = 1'b0;
		bpi_dsbl = 1'b0;
		bpi_enbl = 1'b0;
		repeat (2) @(negedge CLK);
		local_rst = 1'b0;
		@(negedge CLK);

		expect_true(!bpi_execute, "bpi_execute high after reset");
		expect_true(bpi_rbk_wrd_cnt == '0, "readback count not zero after reset");
		expect_true(bpi_status == 16'h8800,
			$sformatf("status %h after reset, expected 8800", bpi_status));

		bpi_enbl = 1'b1;
		@(negedge CLK);
		bpi_enbl = 1'b0;

		a = 23'h123450;
		read_words(a, 8);
		for (int i = 0; i < 8; i++)
			expect_true(rbk_words[i] == flash.mem[a + flash_addr_t'(i)],
				$sformatf("word %0d read %h", i, rbk_words[i]));

		// Program clears bits only
		a = 23'h123460;
		old_word = flash.mem[a];
		load_address(a);
		write_word({11'd0, cmd_program});
		write_word(16'h5A3C);
		wait_done("Program");
		expect_true(bpi_status[7:0] == 8'h80,
			$sformatf("status byte %h after program", bpi_status[7:0]));
		read_words(a, 1);
		expect_true(rbk_words[0] == (old_word & 16'h5A3C),
			$sformatf("programmed word %h, expected %h", rbk_words[0], old_word & 16'h5A3C));

		erase_and_check(23'h7F5123, 23'h7F4000);  // 16 K-word parameter block
		erase_and_check(23'h2A1234, 23'h2A0000);  // 64 K-word main block

		load_address(PROT_ADDR);
		write_word({11'd0, cmd_program});
		write_word(16'h0F0F);
		wait_done("Program to protected word");
		expect_true(bpi_status[7:0] == 8'h90,
			$sformatf("status byte %h after protected program", bpi_status[7:0]));
		send_cmd(cmd_clr_status_reg, '0);
		wait_done("Clr_Status_Reg");
		send_cmd(cmd_read_status_reg, '0);
		wait_done("Read_Status_Reg");
		expect_true(bpi_status[7:0] == 8'h80,
			$sformatf("status byte %h after clear", bpi_status[7:0]));

		// No bus cycle while the parser is disabled
		bpi_dsbl = 1'b1;
		@(negedge CLK);
		bpi_dsbl = 1'b0;
		send_cmd(cmd_read_status_reg, '0);
		repeat (100)
		begin
			@(negedge CLK);
			expect_true(!bpi_execute, "bus cycle while parser disabled");
		end
		expect_true(bpi_rbk_wrd_cnt == '0, "readback FIFO not empty before underflow");
		pop_word(w);
		expect_true(bpi_status[13], "readback underflow bit not set");
		send_cmd(cmd_clr_bpi_status, '0);
		repeat (10) @(negedge CLK);
		expect_true(bpi_status[13], "underflow bit cleared while parser disabled");
		bpi_enbl = 1'b1;
		@(negedge CLK);
		bpi_enbl = 1'b0;
		n = 0;
		while (bpi_status[13])
		begin
			@(negedge CLK);
			n++;
			if (n > TIMEOUT)
				stop_run("Timed out waiting for Clr_BPI_Status to clear bit 13");
		end

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
hw/bpi_pkg.sv
hw/bpi_fifo.sv
hw/bpi_cmd_decode.sv
hw/bpi_execute.sv
hw/bpi_result.sv
hw/bpi_ctrl.sv
bench/bpi_flash_model.sv
bench/bpi_ctrl_asserts.sv
bench/bpi_ctrl_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module bpi_ctrl_tb -f flist.f

sim_status=0
output=$(./obj_dir/Vbpi_ctrl_tb 2>&1) || sim_status=$?
echo "$output"
echo "simulator exit status: $sim_status"
echo "$output" | grep -q "^Regression passed$"
